/* logic/dmm_pkg.sv */
// dmm control package with register map, widths, mode and state codes and the pin bundle
package dmm_pkg;

  //////////////////////////////////////////////////
  // widths with a meaning
  typedef logic [23:0] reg_word_t;   // data part of every spi frame
  typedef logic [7:0]  reg_addr_t;   // msb set marks a read-only access
  typedef logic [23:0] count_t;      // clk cycle count
  typedef logic [5:0]  seq_step_t;   // {pc_sw[1:0], azmux[3:0]}

  //////////////////////////////////////////////////
  // register map
  localparam reg_addr_t REG_SPI_MUX   = 8'd8;
  localparam reg_addr_t REG_4094      = 8'd9;
  localparam reg_addr_t REG_MODE      = 8'd12;
  localparam reg_addr_t REG_DIRECT    = 8'd14;
  localparam reg_addr_t REG_STATUS    = 8'd16;   // read only
  localparam reg_addr_t REG_PRECHARGE = 8'd20;
  localparam reg_addr_t REG_APERTURE  = 8'd21;
  localparam reg_addr_t REG_SEQ_N     = 8'd22;
  localparam reg_addr_t REG_SEQ0      = 8'd23;
  localparam reg_addr_t REG_SEQ1      = 8'd24;
  localparam reg_addr_t REG_SEQ2      = 8'd25;
  localparam reg_addr_t REG_SEQ3      = 8'd26;

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;   // low byte of status

  // output mode, codes 5..7 behave as all low
  typedef enum logic [2:0] {
    MODE_DIRECT  = 3'd0,
    MODE_LO      = 3'd1,
    MODE_HI      = 3'd2,
    MODE_PATTERN = 3'd3,
    MODE_AZ_TEST = 3'd4
  } mode_t;

  // host spi routing, code 3 behaves as none
  typedef enum logic [1:0] {
    ROUTE_NONE = 2'd0,
    ROUTE_4094 = 2'd1,
    ROUTE_DAC  = 2'd2
  } spi_route_t;

  // board pins, same bit order as reg_direct[19:0]
  typedef struct packed {
    logic       meas_complete;   // 19
    logic       spi_interrupt;   // 18
    logic [3:0] azmux;           // 17:14
    logic [1:0] pc_sw;           // 13:12
    logic [7:0] monitor;         // 11:4
    logic [3:0] leds;            // 3:0
  } out_pins_t;

  // acquisition setup, built in the register bank
  typedef struct packed {
    count_t              precharge;
    count_t              aperture;
    logic [1:0]          seq_n;   // steps minus one
    seq_step_t [3:0]     seq;
  } acq_cfg_t;

  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    PRECHARGE = 2'd1,
    SAMPLE    = 2'd2
  } seq_state_t;

endpackage

/* logic/spi_register_bank.sv */
// spi register bank, oversampled spi slave with the control registers and status readback
`timescale 1ns/1ps

module spi_register_bank #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                sck_i,
  input  logic                sdi_i,
  input  logic                ss_i,         // active low
  input  logic [3:0]          hw_flags_i,
  output logic                sdo_o,
  output dmm_pkg::mode_t      mode_o,
  output dmm_pkg::spi_route_t route_o,
  output logic                oe_4094_o,
  output dmm_pkg::out_pins_t  direct_o,
  output dmm_pkg::acq_cfg_t   cfg_o
);
  import dmm_pkg::*;

  typedef struct packed {
    logic ss;
    logic sck;
    logic sdi;
  } spi_pins_t;

  localparam spi_pins_t PINS_IDLE = '{ss: 1'b1, sck: 1'b0, sdi: 1'b0};  // deselected, mode 0

  spi_pins_t [SYNC_STAGES-1:0] sync_q;   // sync chain, [0] is first flop
  spi_pins_t   pins_s;                   // synchronized pins
  spi_pins_t   pins_d;                   // one cycle older, for edges
  logic        sck_rise;
  logic        sck_fall;
  logic        frame_end;                // ss released
  logic [31:0] shift_q;                  // addr byte then data
  logic [5:0]  bit_cnt_q;                // saturates at 63
  reg_addr_t   rd_addr;
  reg_word_t   rd_word;
  reg_word_t   rd_q;                     // readback shifter
  logic        sdo_q;
  logic        wr_en;

  reg_word_t   spi_mux_q;
  reg_word_t   reg_4094_q;
  reg_word_t   mode_q;
  reg_word_t   direct_q;
  reg_word_t   precharge_q;
  reg_word_t   aperture_q;
  reg_word_t   seq_n_q;
  reg_word_t   seq_q [4];
  logic [11*24-1:0] reg_image;           // every writable bit, for the check below

  //////////////////////////////////////////////////
  // pin synchronizer and edge detect
  always_ff @(posedge clk) begin
    if (rst_i) begin
      sync_q <= {SYNC_STAGES{PINS_IDLE}};
      pins_d <= PINS_IDLE;
    end else begin
      sync_q[0] <= {ss_i, sck_i, sdi_i};
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      pins_d <= pins_s;
    end
  end

  assign pins_s    = sync_q[SYNC_STAGES-1];
  assign sck_rise  = pins_s.sck & ~pins_d.sck & ~pins_s.ss;  // only while selected
  assign sck_fall  = ~pins_s.sck & pins_d.sck & ~pins_s.ss;
  assign frame_end = pins_s.ss & ~pins_d.ss;
  assign rd_addr   = {shift_q[6:0], pins_s.sdi};             // address as the 8th bit lands

  //////////////////////////////////////////////////
  // frame shifter, bit counter and sdo
  always_ff @(posedge clk) begin
    if (rst_i) begin
      shift_q   <= '0;
      bit_cnt_q <= '0;
      rd_q      <= '0;
      sdo_q     <= 1'b0;
    end else if (pins_s.ss) begin
      bit_cnt_q <= '0;    // idle between frames
      sdo_q     <= 1'b0;
    end else begin
      if (sck_rise) begin
        shift_q <= {shift_q[30:0], pins_s.sdi};
        if (bit_cnt_q != 6'h3f) begin
          bit_cnt_q <= bit_cnt_q + 6'd1;
        end
        if (bit_cnt_q == 6'd7) begin
          rd_q <= rd_word;  // old contents, before any write
        end
      end
      if (sck_fall) begin
        if (bit_cnt_q >= 6'd8 && bit_cnt_q < 6'd32) begin
          sdo_q <= rd_q[23];               // msb first, valid for next rise
          rd_q  <= {rd_q[22:0], 1'b0};
        end else begin
          sdo_q <= 1'b0;                   // low during address bits
        end
      end
    end
  end

  // readback mux, read-only flag ignored here
  always_comb begin
    case ({1'b0, rd_addr[6:0]})
      REG_SPI_MUX:   rd_word = spi_mux_q;
      REG_4094:      rd_word = reg_4094_q;
      REG_MODE:      rd_word = mode_q;
      REG_DIRECT:    rd_word = direct_q;
      REG_STATUS:    rd_word = {12'b0, hw_flags_i, STATUS_MAGIC};
      REG_PRECHARGE: rd_word = precharge_q;
      REG_APERTURE:  rd_word = aperture_q;
      REG_SEQ_N:     rd_word = seq_n_q;
      REG_SEQ0:      rd_word = seq_q[0];
      REG_SEQ1:      rd_word = seq_q[1];
      REG_SEQ2:      rd_word = seq_q[2];
      REG_SEQ3:      rd_word = seq_q[3];
      default:       rd_word = '0;        // unknown address
    endcase
  end

  //////////////////////////////////////////////////
  // register write on ss release
  assign wr_en = frame_end && bit_cnt_q == 6'd32 && !shift_q[31];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      spi_mux_q   <= '0;
      reg_4094_q  <= '0;
      mode_q      <= '0;
      direct_q    <= '0;
      precharge_q <= '0;
      aperture_q  <= '0;
      seq_n_q     <= '0;
      for (int k = 0; k < 4; k++) begin
        seq_q[k] <= '0;
      end
    end else if (wr_en) begin
      case (reg_addr_t'(shift_q[31:24]))
        REG_SPI_MUX:   spi_mux_q   <= shift_q[23:0];
        REG_4094:      reg_4094_q  <= shift_q[23:0];
        REG_MODE:      mode_q      <= shift_q[23:0];
        REG_DIRECT:    direct_q    <= shift_q[23:0];
        REG_PRECHARGE: precharge_q <= shift_q[23:0];
        REG_APERTURE:  aperture_q  <= shift_q[23:0];
        REG_SEQ_N:     seq_n_q     <= shift_q[23:0];
        REG_SEQ0:      seq_q[0]    <= shift_q[23:0];
        REG_SEQ1:      seq_q[1]    <= shift_q[23:0];
        REG_SEQ2:      seq_q[2]    <= shift_q[23:0];
        REG_SEQ3:      seq_q[3]    <= shift_q[23:0];
        default: ;                                   // status or unknown, dropped
      endcase
    end
  end

  assign sdo_o     = sdo_q;
  assign mode_o    = mode_t'(mode_q[2:0]);
  assign route_o   = spi_route_t'(spi_mux_q[1:0]);
  assign oe_4094_o = reg_4094_q[0];                  // lo at power up, 4094 disabled
  assign direct_o  = out_pins_t'(direct_q[19:0]);

  always_comb begin
    cfg_o.precharge = precharge_q;
    cfg_o.aperture  = aperture_q;
    cfg_o.seq_n     = seq_n_q[1:0];
    for (int k = 0; k < 4; k++) begin
      cfg_o.seq[k] = seq_q[k][5:0];
    end
  end

  assign reg_image = {spi_mux_q, reg_4094_q, mode_q, direct_q, precharge_q, aperture_q,
                      seq_n_q, seq_q[0], seq_q[1], seq_q[2], seq_q[3]};

  // any register change must come from a full 32 bit frame one cycle earlier
  a_write_full_frame : assert property (@(posedge clk) disable iff (rst_i)
    !$stable(reg_image) |-> $past(frame_end && bit_cnt_q == 6'd32));

endmodule

/* logic/adc_mock.sv */
// mock adc, reports a finished measurement one aperture after release
`timescale 1ns/1ps

module adc_mock (
  input  logic            clk,
  input  logic            rst_i,
  input  logic            adc_release_i,   // level, held for the whole sample
  input  dmm_pkg::count_t aperture_i,
  output logic            measure_valid_o, // one cycle pulse
  output logic [3:0]      monitor_o
);
  import dmm_pkg::*;

  count_t cnt_q;   // cycles since release

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (!adc_release_i) begin
      cnt_q <= '0;                // held in reset
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // hits once per release, count runs on past aperture
  assign measure_valid_o = adc_release_i && cnt_q == aperture_i;

  assign monitor_o = cnt_q[23:20];   // coarse progress

endmodule

/* logic/sequence_acquisition.sv */
// autozero sequence controller, steps precharge and sample phases through the programmed steps
`timescale 1ns/1ps

module sequence_acquisition (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               run_i,            // level, trigger gated by mode
  input  dmm_pkg::acq_cfg_t  cfg_i,
  input  logic               measure_valid_i,  // from adc
  output logic               adc_release_o,
  output dmm_pkg::out_pins_t pins_o
);
  import dmm_pkg::*;

  seq_state_t state_q;
  count_t     pc_cnt_q;    // precharge cycles left
  logic [1:0] step_q;      // current step index
  logic       done_q;      // end of pass pulse
  seq_step_t  cur_step;
  logic       last_step;

  assign cur_step  = cfg_i.seq[step_q];
  assign last_step = step_q == cfg_i.seq_n;

  //////////////////////////////////////////////////
  // fsm
  always_ff @(posedge clk) begin
    if (rst_i || !run_i) begin
      state_q  <= IDLE;
      pc_cnt_q <= '0;
      step_q   <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          state_q  <= PRECHARGE;          // start at step 0
          pc_cnt_q <= cfg_i.precharge;
        end
        PRECHARGE: begin
          if (pc_cnt_q == '0) begin
            state_q <= SAMPLE;            // precharge+1 cycles spent
          end else begin
            pc_cnt_q <= pc_cnt_q - 1'b1;
          end
        end
        SAMPLE: begin
          if (measure_valid_i) begin
            state_q  <= PRECHARGE;
            pc_cnt_q <= cfg_i.precharge;
            done_q   <= last_step;        // full pass finished
            if (last_step) begin
              step_q <= 2'd0;             // wrap
            end else begin
              step_q <= step_q + 2'd1;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // adc released for the whole sample phase
  assign adc_release_o = state_q == SAMPLE;

  //////////////////////////////////////////////////
  // pin drive
  always_comb begin
    pins_o               = '0;
    pins_o.meas_complete = done_q;
    pins_o.spi_interrupt = done_q;              // host sees the same strobe
    pins_o.monitor       = {4'b0, step_q, state_q};
    if (state_q != IDLE) begin
      pins_o.azmux = cur_step[3:0];             // held through both phases
      pins_o.leds  = 4'b0001 << step_q;         // one-hot step
      if (state_q == SAMPLE) begin
        pins_o.pc_sw = cur_step[5:4];           // switches off while precharging
      end
    end
  end

  // the mock adc only answers a released sample
  a_valid_in_sample : assert property (@(posedge clk) disable iff (rst_i)
    measure_valid_i |-> state_q == SAMPLE);

endmodule

/* logic/output_mode_mux.sv */
// output mode mux, registers the board pins for the active mode and routes the host spi bus
`timescale 1ns/1ps

module output_mode_mux (
  input  logic                clk,
  input  logic                rst_i,
  input  dmm_pkg::mode_t      mode_i,
  input  dmm_pkg::spi_route_t route_i,
  input  logic                oe_4094_i,
  input  dmm_pkg::out_pins_t  direct_i,
  input  dmm_pkg::out_pins_t  seq_pins_i,
  input  logic                sck_i,
  input  logic                sdi_i,
  input  logic                spi_cs2_i,       // active low
  output dmm_pkg::out_pins_t  pins_o,
  output logic                glb_spi_clk_o,
  output logic                glb_spi_mosi_o,
  output logic                glb_4094_strobe_o,
  output logic                glb_4094_oe_o,
  output logic                spi_dac_ss_o
);
  import dmm_pkg::*;

  logic [$bits(out_pins_t)-1:0] pattern_q;   // free running
  out_pins_t                    pins_next;
  logic                         route_on;

  //////////////////////////////////////////////////
  // board pin select
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pattern_q <= '0;
    end else begin
      pattern_q <= pattern_q + 1'b1;
    end
  end

  always_comb begin
    case (mode_i)
      MODE_DIRECT:  pins_next = direct_i;
      MODE_LO:      pins_next = '0;
      MODE_HI:      pins_next = '1;
      MODE_PATTERN: pins_next = out_pins_t'(pattern_q);
      MODE_AZ_TEST: pins_next = seq_pins_i;
      default:      pins_next = '0;        // 5..7 as all low
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pins_o <= '0;
    end else begin
      pins_o <= pins_next;   // one cycle behind source
    end
  end

  //////////////////////////////////////////////////
  // host spi routing, combinational
  assign route_on = route_i == ROUTE_4094 || route_i == ROUTE_DAC;   // code 3 parks

  assign glb_spi_clk_o     = route_on ? sck_i : 1'b1;               // park hi
  assign glb_spi_mosi_o    = route_on ? sdi_i : 1'b1;
  assign glb_4094_strobe_o = route_i == ROUTE_4094 ? ~spi_cs2_i : 1'b0;   // active hi
  assign spi_dac_ss_o      = route_i == ROUTE_DAC ? spi_cs2_i : 1'b1;     // active lo
  assign glb_4094_oe_o     = oe_4094_i;

  // never latch the 4094 while the dac is selected
  a_one_device : assert property (@(posedge clk)
    !(glb_4094_strobe_o && !spi_dac_ss_o));

endmodule

/* logic/dmm_top.sv */
// dmm front end control top, spi registers, autozero sequencer, mock adc and output muxing
`timescale 1ns/1ps

module dmm_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       sck_i,
  input  logic       sdi_i,
  input  logic       ss_i,
  output logic       sdo_o,
  input  logic       spi_cs2_i,
  input  logic [3:0] hw_flags_i,
  input  logic       trigger_i,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic       spi_interrupt_o,
  output logic       meas_complete_o,
  output logic       glb_spi_clk_o,
  output logic       glb_spi_mosi_o,
  output logic       glb_4094_strobe_o,
  output logic       glb_4094_oe_o,
  output logic       spi_dac_ss_o
);
  import dmm_pkg::*;

  mode_t      mode;
  spi_route_t route;
  logic       oe_4094;
  out_pins_t  direct_pins;
  out_pins_t  seq_pins;
  out_pins_t  board_pins;
  acq_cfg_t   acq_cfg;
  logic       adc_release;
  logic       measure_valid;
  logic       seq_run;

  assign seq_run = trigger_i && mode == MODE_AZ_TEST;   // sequencer idles otherwise

  spi_register_bank #(.SYNC_STAGES(SYNC_STAGES)) u_regs (
    .clk, .rst_i, .sck_i, .sdi_i, .ss_i, .hw_flags_i, .sdo_o,
    .mode_o(mode), .route_o(route), .oe_4094_o(oe_4094),
    .direct_o(direct_pins), .cfg_o(acq_cfg)
  );

  sequence_acquisition u_seq (
    .clk, .rst_i, .run_i(seq_run), .cfg_i(acq_cfg),
    .measure_valid_i(measure_valid), .adc_release_o(adc_release), .pins_o(seq_pins)
  );

  adc_mock u_adc (
    .clk, .rst_i, .adc_release_i(adc_release), .aperture_i(acq_cfg.aperture),
    .measure_valid_o(measure_valid), .monitor_o()   // count monitor left off the pins
  );

  output_mode_mux u_out (
    .clk, .rst_i, .mode_i(mode), .route_i(route), .oe_4094_i(oe_4094),
    .direct_i(direct_pins), .seq_pins_i(seq_pins), .sck_i, .sdi_i, .spi_cs2_i,
    .pins_o(board_pins), .glb_spi_clk_o, .glb_spi_mosi_o, .glb_4094_strobe_o,
    .glb_4094_oe_o, .spi_dac_ss_o
  );

  //////////////////////////////////////////////////
  // board pin breakout
  assign leds_o          = board_pins.leds;
  assign monitor_o       = board_pins.monitor;
  assign pc_sw_o         = board_pins.pc_sw;
  assign azmux_o         = board_pins.azmux;
  assign spi_interrupt_o = board_pins.spi_interrupt;
  assign meas_complete_o = board_pins.meas_complete;

endmodule

/* bench/dmm_spi_tasks.svh */
// spi frame driver for the host bus and typed compare tasks for the dmm control testbench
`ifndef DMM_SPI_TASKS_SVH
`define DMM_SPI_TASKS_SVH

//////////////////////////////////////////////////
// host spi, mode 0, msb first

// sends the top nbits of a frame, collects sdo during the data bits
task automatic spi_frame(input int nbits, input logic [31:0] frame, output reg_word_t rd);
  rd = '0;
  @(negedge clk);
  ss_i  = 1'b0;
  sck_i = 1'b0;
  for (int i = 0; i < nbits; i++) begin
    sdi_i = frame[31-i];
    repeat (SPI_HALF) @(negedge clk);
    if (i >= 8) begin
      rd = {rd[22:0], sdo_o};   // valid ahead of the rising edge
    end
    sck_i = 1'b1;
    repeat (SPI_HALF) @(negedge clk);
    sck_i = 1'b0;
  end
  repeat (SPI_HALF) @(negedge clk);
  ss_i  = 1'b1;
  sdi_i = 1'b0;
  // write lands within SYNC_STAGES+2 cycles of ss release
  repeat (SPI_HALF) @(negedge clk);
endtask

task automatic spi_write(input reg_addr_t addr, input reg_word_t data);
  reg_word_t unused_rd;
  spi_frame(32, {addr, data}, unused_rd);
endtask

// address msb set, so the frame never writes
task automatic spi_read(input reg_addr_t addr, output reg_word_t data);
  spi_frame(32, {addr | 8'h80, 24'h0}, data);
endtask

//////////////////////////////////////////////////
// compares, one per result type
task automatic check_word(input string name, input reg_word_t got, input reg_word_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
  end
endtask

task automatic check_pins(input string name, input out_pins_t got, input out_pins_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
  end
endtask

`endif

/* bench/dmm_top_tb.sv */
// testbench for the dmm front end control, random register, mode, routing and autozero tests
`timescale 1ns/1ps

module dmm_top_tb;
  import dmm_pkg::*;

  localparam int SPI_HALF  = 6;                               // clk cycles per sck phase
  localparam int FRAME_CYC = 32*2*SPI_HALF + 2*SPI_HALF + 1;  // one spi_frame call
  // frames per test: readback 38, modes 5, pattern 1, routing 8, autozero 8
  localparam int PLAN_CYC  = (38 + 5 + 1 + 8 + 8) * FRAME_CYC + 400;
  localparam int LIMIT     = 2 * PLAN_CYC;

  localparam reg_addr_t WR_LIST [11] = '{REG_SPI_MUX, REG_4094, REG_MODE, REG_DIRECT,
    REG_PRECHARGE, REG_APERTURE, REG_SEQ_N, REG_SEQ0, REG_SEQ1, REG_SEQ2, REG_SEQ3};

  logic       clk;
  logic       rst_i;
  logic       sck_i;
  logic       sdi_i;
  logic       ss_i;
  logic       spi_cs2_i;
  logic [3:0] hw_flags_i;
  logic       trigger_i;
  logic       sdo_o;
  logic [3:0] leds_o;
  logic [7:0] monitor_o;
  logic [1:0] pc_sw_o;
  logic [3:0] azmux_o;
  logic       spi_interrupt_o;
  logic       meas_complete_o;
  logic       glb_spi_clk_o;
  logic       glb_spi_mosi_o;
  logic       glb_4094_strobe_o;
  logic       glb_4094_oe_o;
  logic       spi_dac_ss_o;
  out_pins_t  pins_seen;        // board pins gathered back into the bundle
  int         errors;
  int         checks;
  int         cycles;
  reg_word_t  model [256];      // register file model, writable addresses only

  assign pins_seen = {meas_complete_o, spi_interrupt_o, azmux_o, pc_sw_o, monitor_o, leds_o};

  dmm_top #(.SYNC_STAGES(2)) dut_i (.*);

  `include "dmm_spi_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run stopped after %0d cycles", cycles);
    $display("TESTS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // model helpers
  function automatic logic is_writable(input reg_addr_t a);
    foreach (WR_LIST[i]) if (a == WR_LIST[i]) return 1'b1;
    return 1'b0;
  endfunction

  function automatic reg_word_t expect_read(input reg_addr_t a);
    reg_addr_t base;
    base = {1'b0, a[6:0]};
    if (base == REG_STATUS) return {12'b0, hw_flags_i, 8'hAA};
    return model[base];   // unknown stays zero
  endfunction

  task automatic write_reg(input reg_addr_t a, input reg_word_t d);
    spi_write(a, d);
    if (is_writable(a)) model[a] = d;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic finish_test(input string name, input int err0);
    $display("%-20s %0d errors", name, errors - err0);
  endtask

  task automatic read_all(input string tag);
    reg_word_t rd;
    foreach (WR_LIST[i]) begin
      spi_read(WR_LIST[i], rd);
      check_word($sformatf("reg %0d %s", WR_LIST[i], tag), rd, expect_read(WR_LIST[i]));
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  task automatic register_readback();
    int err0;
    reg_word_t rd;
    err0 = errors;
    foreach (WR_LIST[i]) write_reg(WR_LIST[i], 24'($urandom));
    read_all("readback");
    spi_read(REG_STATUS, rd);
    check_word("status", rd, {12'b0, hw_flags_i, 8'hAA});
    write_reg(REG_STATUS, 24'($urandom));        // read only, dropped
    spi_frame(31, {REG_MODE, 24'($urandom)}, rd); // short frame, dropped
    read_all("after dropped writes");
    spi_read(REG_STATUS, rd);
    check_word("status after write", rd, {12'b0, hw_flags_i, 8'hAA});
    spi_read(8'd3, rd);
    check_word("unknown reg 3", rd, 24'h0);
    finish_test("register readback", err0);
  endtask

  task automatic static_modes();
    int err0;
    reg_word_t w;
    err0 = errors;
    w = 24'($urandom);
    write_reg(REG_MODE, 24'(MODE_DIRECT));
    write_reg(REG_DIRECT, w);
    wait_cycles(2);
    check_pins("pins in direct", pins_seen, out_pins_t'(w[19:0]));
    write_reg(REG_MODE, 24'(MODE_LO));
    wait_cycles(2);
    check_pins("pins in low", pins_seen, '0);
    write_reg(REG_MODE, 24'(MODE_HI));
    wait_cycles(2);
    check_pins("pins in high", pins_seen, '1);
    write_reg(REG_MODE, 24'd6);                  // spare code, all low
    wait_cycles(2);
    check_pins("pins in mode 6", pins_seen, '0);
    finish_test("direct, low, high", err0);
  endtask

  task automatic pattern_count();
    int err0;
    logic [19:0] prev_v;
    err0 = errors;
    write_reg(REG_MODE, 24'(MODE_PATTERN));
    wait_cycles(2);
    prev_v = pins_seen;                          // counter phase set by reset timing
    repeat (64) begin
      @(negedge clk);
      prev_v = prev_v + 20'd1;                   // wraps at 2^20
      check_pins("pattern pins", pins_seen, out_pins_t'(prev_v));
    end
    finish_test("test pattern", err0);
  endtask

  task automatic spi_routing();
    int err0;
    logic on;
    err0 = errors;
    for (int r = 0; r < 4; r++) begin
      write_reg(REG_SPI_MUX, 24'(r));
      write_reg(REG_4094, 24'($urandom));
      on = r == 1 || r == 2;                     // 0 and 3 park the bus
      repeat (16) begin
        @(negedge clk);
        sck_i     = 1'($urandom);
        sdi_i     = 1'($urandom);
        spi_cs2_i = 1'($urandom);
        @(posedge clk);
        check_bit("glb_spi_clk_o", glb_spi_clk_o, on ? sck_i : 1'b1);
        check_bit("glb_spi_mosi_o", glb_spi_mosi_o, on ? sdi_i : 1'b1);
        check_bit("glb_4094_strobe_o", glb_4094_strobe_o, r == 1 ? ~spi_cs2_i : 1'b0);
        check_bit("spi_dac_ss_o", spi_dac_ss_o, r == 2 ? spi_cs2_i : 1'b1);
        check_bit("glb_4094_oe_o", glb_4094_oe_o, model[REG_4094][0]);
      end
    end
    @(negedge clk);
    sck_i     = 1'b0;
    sdi_i     = 1'b0;
    spi_cs2_i = 1'b1;
    finish_test("spi routing", err0);
  endtask

  task automatic autozero_sequence();
    int err0;
    int guard;
    int pulses;
    count_t pc;
    count_t ap;
    logic [1:0] n;
    seq_step_t steps [4];
    reg_word_t w;
    out_pins_t exp;
    logic first;
    logic pre;
    logic done;
    err0 = errors;
    pc = 24'($urandom % 5);
    ap = 24'($urandom % 5);
    n  = 2'($urandom);
    write_reg(REG_PRECHARGE, pc);
    write_reg(REG_APERTURE, ap);
    write_reg(REG_SEQ_N, {22'($urandom), n});
    for (int k = 0; k < 4; k++) begin
      steps[k] = {2'($urandom), 4'(1 + $urandom % 15)};   // mux never zero
      w = 24'($urandom);
      w[5:0] = steps[k];
      write_reg(reg_addr_t'(REG_SEQ0 + k), w);
    end
    write_reg(REG_MODE, 24'(MODE_AZ_TEST));
    wait_cycles(2);
    check_pins("pins before trigger", pins_seen, '0);
    trigger_i = 1'b1;
    guard = 0;
    while (pins_seen.azmux == 4'h0 && guard < 20) begin
      @(negedge clk);
      guard++;
    end
    if (guard == 20) begin
      errors++;
      $display("azmux_o never left zero after trigger_i rose");
    end
    first  = 1'b1;
    pulses = 0;
    // three passes, every step precharge+aperture+2 cycles long
    for (int pass = 0; pass < 3; pass++) begin
      for (int k = 0; k <= int'(n); k++) begin
        for (int c = 0; c <= int'(pc) + int'(ap) + 1; c++) begin
          if (!first) @(negedge clk);
          first = 1'b0;
          pre  = c <= int'(pc);
          done = pass > 0 && k == 0 && c == 0;   // end of the previous pass
          exp  = '0;
          exp.azmux         = steps[k][3:0];
          exp.pc_sw         = pre ? 2'b00 : steps[k][5:4];
          exp.leds          = 4'(1 << k);
          exp.monitor       = {4'b0, 2'(k), pre ? 2'(PRECHARGE) : 2'(SAMPLE)};
          exp.meas_complete = done;
          exp.spi_interrupt = done;
          check_pins($sformatf("az pins step %0d", k), pins_seen, exp);
          if (meas_complete_o) pulses++;
        end
      end
    end
    if (pulses != 2) begin
      errors++;
      $display("meas_complete_o pulsed %0d times over 2 finished passes", pulses);
    end
    @(negedge clk);
    trigger_i = 1'b0;
    wait_cycles(3);
    check_pins("pins after trigger drop", pins_seen, '0);
    finish_test("autozero sequence", err0);
  endtask

  //////////////////////////////////////////////////
  // main
  initial begin
    void'($urandom(32'h82c5));   // fixed seed for the whole run
    rst_i      = 1'b1;
    sck_i      = 1'b0;
    sdi_i      = 1'b0;
    ss_i       = 1'b1;
    spi_cs2_i  = 1'b1;
    trigger_i  = 1'b0;
    hw_flags_i = 4'h0;
    errors     = 0;
    checks     = 0;
    for (int a = 0; a < 256; a++) model[a] = '0;
    repeat (5) @(negedge clk);
    rst_i      = 1'b0;
    hw_flags_i = 4'($urandom);
    register_readback();
    static_modes();
    pattern_count();
    spi_routing();
    autozero_sequence();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* dmm_ctrl.f */
+incdir+bench
logic/dmm_pkg.sv
logic/spi_register_bank.sv
logic/adc_mock.sv
logic/sequence_acquisition.sv
logic/output_mode_mux.sv
logic/dmm_top.sv
bench/dmm_top_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = dmm_top_tb
FILELIST = dmm_ctrl.f
BUILD    = obj_dir

SIM      = $(BUILD)/V$(TOP)
SOURCES  = $(filter-out +incdir%,$(shell cat $(FILELIST))) $(wildcard bench/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD)
